//--- verilog/frep_pkg.sv
/*
 * FREP front end shared types
 * Holds the instruction word views, the loop configuration that the
 * decoder hands to the sequencer, and the opcode that marks a loop header
 */

`default_nettype none

package frep_pkg;

    //////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////

    // Body length in words, 1 to 16, so it needs five bits
    localparam int unsigned BODY_LEN_W = 5;
    // Extra repetitions, the body runs max_rep plus one times
    localparam int unsigned MAX_REP_W  = 12;

    // Opcode that turns an instruction word into a loop header
    localparam logic [7:0] FREP_OPCODE = 8'h8b;

    //////////////////////////////////////////////////
    // Instruction word views
    //////////////////////////////////////////////////

    // Loop header layout, opcode in the top byte
    typedef struct packed {
        logic [7:0]           opcode;
        logic [7:0]           reserved;
        logic [MAX_REP_W-1:0] max_rep;
        logic [3:0]           body_len_m1;
    } frep_hdr_t;

    // Plain floating-point operation, opcode in the same place as the header
    typedef struct packed {
        logic [7:0] opcode;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [8:0] funct;
    } fp_op_t;

    // One 32-bit word, read as a header or as an operation by its opcode
    typedef union packed {
        logic [31:0] raw;
        frep_hdr_t   hdr;
        fp_op_t      op;
    } insn_u;

    // Loop configuration passed from decoder to sequencer
    typedef struct packed {
        logic [BODY_LEN_W-1:0] body_len;
        logic [MAX_REP_W-1:0]  max_rep;
    } loop_cfg_t;

endpackage

`default_nettype wire

//--- verilog/insn_ring_buffer.sv
/*
 * Instruction ring buffer
 * Sequential writes from the loop decoder, random reads by the sequencer
 * inside the occupied range, and a read pointer that only moves when the
 * sequencer releases a whole block through advance and step
 */

`timescale 1ns/1ps
`default_nettype none

module insn_ring_buffer #(
    parameter int unsigned DEPTH = 16,
    localparam int unsigned ADDR_W = $clog2(DEPTH),
    localparam int unsigned STEP_W = $clog2(DEPTH + 1)
) (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,

    // Sequential write port
    input  wire logic              wr_valid_i,
    output logic                   wr_ready_o,
    input  wire frep_pkg::insn_u   wr_data_i,

    // Random access read port, bounded to the occupied range
    input  wire logic              rd_valid_i,
    output logic                   rd_ready_o,
    input  wire logic [ADDR_W-1:0] rd_addr_i,
    output frep_pkg::insn_u        rd_data_o,

    // Read pointer release
    input  wire logic              advance_i,
    input  wire logic [STEP_W-1:0] step_i,

    // Status
    output logic [ADDR_W-1:0]      rptr_o,
    output logic                   empty_o
);

    import frep_pkg::*;

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////

    insn_u mem_q [DEPTH];

    // Pointers carry one extra wrap bit so full and empty differ
    logic [ADDR_W:0] wptr_q;
    logic [ADDR_W:0] rptr_q;

    // Number of occupied entries, 0 to DEPTH
    logic [ADDR_W:0] count;
    // Distance of the requested address from the read pointer
    logic [ADDR_W-1:0] rd_offset;
    logic full;
    logic wr_fire;

    assign count     = wptr_q - rptr_q;
    assign empty_o   = (count == '0);
    // Full only when the count has reached DEPTH, which sets the top bit
    assign full      = count[ADDR_W];
    assign wr_fire   = wr_valid_i && wr_ready_o;

    assign wr_ready_o = !full;

    // Entries are written in order at the write pointer
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            mem_q[wptr_q[ADDR_W-1:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            if (wr_fire) begin
                wptr_q <= wptr_q + 1'b1;
            end
            // A whole block is freed at once, step is its body length
            if (advance_i) begin
                rptr_q <= rptr_q + (ADDR_W + 1)'(step_i);
            end
        end
    end

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////

    // Modulo distance handles the wrapped case without extra compares
    assign rd_offset = rd_addr_i - rptr_q[ADDR_W-1:0];

    // The request is served only once the address holds a written word,
    // so the sequencer simply waits for the decoder to catch up
    assign rd_ready_o = rd_valid_i && ({1'b0, rd_offset} < count);

    // Same-cycle read data
    assign rd_data_o = mem_q[rd_addr_i];

    assign rptr_o = rptr_q[ADDR_W-1:0];

endmodule

`default_nettype wire

//--- verilog/frep_decoder.sv
/*
 * FREP loop decoder
 * Splits the input stream into loop headers, body words and standalone
 * operations, writes all but the headers into the ring buffer and hands
 * one loop configuration per block to the sequencer
 */

`timescale 1ns/1ps
`default_nettype none

module frep_decoder (
    input  wire logic               clk_i,
    input  wire logic               rst_n_i,

    // Instruction input
    input  wire logic               in_valid_i,
    output logic                    in_ready_o,
    input  wire frep_pkg::insn_u    in_insn_i,

    // Ring buffer write side
    output logic                    wr_valid_o,
    input  wire logic               wr_ready_i,
    output frep_pkg::insn_u         wr_data_o,

    // Configuration towards the sequencer
    output logic                    cfg_valid_o,
    output frep_pkg::loop_cfg_t     cfg_o,
    input  wire logic               cfg_take_i
);

    import frep_pkg::*;

    // Body words still expected after the last header
    logic [BODY_LEN_W-1:0] body_rem_q;
    logic                  cfg_valid_q;
    loop_cfg_t             cfg_q;
    loop_cfg_t             cfg_d;

    logic body_open;
    logic is_hdr;
    logic slot_free;
    logic in_fire;
    logic new_cfg;

    assign body_open = (body_rem_q != '0);
    // Outside a body the opcode decides how the word is read
    assign is_hdr    = (in_insn_i.hdr.opcode == FREP_OPCODE);
    // The pending configuration leaves this cycle or there is none
    assign slot_free = !cfg_valid_q || cfg_take_i;

    always_comb begin
        if (body_open) begin
            // Body words go straight through to the buffer
            in_ready_o = wr_ready_i;
            wr_valid_o = in_valid_i;
        end else if (is_hdr) begin
            // Headers only need a free configuration slot
            in_ready_o = slot_free;
            wr_valid_o = 1'b0;
        end else begin
            in_ready_o = slot_free && wr_ready_i;
            wr_valid_o = in_valid_i && slot_free;
        end
    end

    assign in_fire   = in_valid_i && in_ready_o;
    assign new_cfg   = in_fire && !body_open;
    assign wr_data_o = in_insn_i;

    // A standalone word is a loop of one word that runs once
    always_comb begin
        if (is_hdr) begin
            cfg_d.body_len = {1'b0, in_insn_i.hdr.body_len_m1} + 1'b1;
            cfg_d.max_rep  = in_insn_i.hdr.max_rep;
        end else begin
            cfg_d.body_len = BODY_LEN_W'(1);
            cfg_d.max_rep  = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            body_rem_q  <= '0;
            cfg_valid_q <= 1'b0;
        end else begin
            if (new_cfg && is_hdr) begin
                body_rem_q <= cfg_d.body_len;
            end else if (in_fire && body_open) begin
                body_rem_q <= body_rem_q - 1'b1;
            end
            if (new_cfg) begin
                cfg_valid_q <= 1'b1;
            end else if (cfg_take_i) begin
                cfg_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (new_cfg) begin
            cfg_q <= cfg_d;
        end
    end

    assign cfg_valid_o = cfg_valid_q;
    assign cfg_o       = cfg_q;

endmodule

`default_nettype wire

//--- verilog/frep_sequencer.sv
/*
 * FREP loop sequencer
 * Takes one loop configuration while idle, replays the buffered body
 * by random reads as many times as requested and then releases the
 * block by stepping the buffer's read pointer past it
 */

`timescale 1ns/1ps
`default_nettype none

module frep_sequencer #(
    parameter int unsigned DEPTH = 16,
    localparam int unsigned ADDR_W = $clog2(DEPTH),
    localparam int unsigned STEP_W = $clog2(DEPTH + 1)
) (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,

    // Configuration from the decoder
    input  wire logic                cfg_valid_i,
    input  wire frep_pkg::loop_cfg_t cfg_i,
    output logic                     cfg_take_o,

    // Ring buffer read side
    input  wire logic [ADDR_W-1:0]   rptr_i,
    output logic                     rd_valid_o,
    input  wire logic                rd_ready_i,
    output logic [ADDR_W-1:0]        rd_addr_o,
    input  wire frep_pkg::insn_u     rd_data_i,
    output logic                     advance_o,
    output logic [STEP_W-1:0]        step_o,

    // Issue port
    output logic                     out_valid_o,
    input  wire logic                out_ready_i,
    output frep_pkg::insn_u          out_insn_o
);

    import frep_pkg::*;

    //////////////////////////////////////////////////
    // Loop state
    //////////////////////////////////////////////////

    logic                  busy_q;
    loop_cfg_t             cfg_q;
    // First entry of the block, the read pointer when it was taken
    logic [ADDR_W-1:0]     base_q;
    logic [BODY_LEN_W-1:0] idx_q;
    logic [MAX_REP_W-1:0]  rep_q;

    logic issue;
    logic last_word;
    logic last_rep;

    // The previous block is released at the edge that ends it, so the
    // read pointer already points at the next block while idle
    assign cfg_take_o = !busy_q && cfg_valid_i;

    assign last_word = (idx_q == cfg_q.body_len - 1'b1);
    assign last_rep  = (rep_q == cfg_q.max_rep);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
            rep_q  <= '0;
        end else if (!busy_q) begin
            if (cfg_valid_i) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
                rep_q  <= '0;
            end
        end else if (issue) begin
            if (last_word) begin
                idx_q <= '0;
                if (last_rep) begin
                    busy_q <= 1'b0;
                end else begin
                    rep_q <= rep_q + 1'b1;
                end
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cfg_take_o) begin
            cfg_q  <= cfg_i;
            base_q <= rptr_i;
        end
    end

    //////////////////////////////////////////////////
    // Read and issue
    //////////////////////////////////////////////////

    // Address arithmetic wraps at DEPTH on its own
    assign rd_valid_o = busy_q;
    assign rd_addr_o  = base_q + ADDR_W'(idx_q);

    // A word is ready once the buffer holds it
    assign out_valid_o = busy_q && rd_ready_i;
    assign out_insn_o  = rd_data_i;

    // Indices only move on an accepted issue, stalls skip nothing
    assign issue = out_valid_o && out_ready_i;

    // Free the whole block after its very last issue
    assign advance_o = issue && last_word && last_rep;
    assign step_o    = STEP_W'(cfg_q.body_len);

endmodule

`default_nettype wire

//--- verilog/frep_top.sv
/*
 * FREP front end top level
 * Loop decoder feeds the instruction ring buffer, the sequencer replays
 * the buffered blocks onto the output
 */

`timescale 1ns/1ps
`default_nettype none

module frep_top #(
    parameter int unsigned DEPTH = 16
) (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             in_valid_i,
    output logic                  in_ready_o,
    input  wire frep_pkg::insn_u  in_insn_i,
    output logic                  out_valid_o,
    input  wire logic             out_ready_i,
    output frep_pkg::insn_u       out_insn_o,
    output logic                  buf_empty_o
);

    import frep_pkg::*;

    localparam int unsigned ADDR_W = $clog2(DEPTH);
    localparam int unsigned STEP_W = $clog2(DEPTH + 1);

    // Decoder to buffer
    logic  wr_valid;
    logic  wr_ready;
    insn_u wr_data;

    // Decoder to sequencer
    logic      cfg_valid;
    loop_cfg_t cfg;
    logic      cfg_take;

    // Sequencer to buffer
    logic              rd_valid;
    logic              rd_ready;
    logic [ADDR_W-1:0] rd_addr;
    insn_u             rd_data;
    logic              advance;
    logic [STEP_W-1:0] step;
    logic [ADDR_W-1:0] rptr;

    frep_decoder u_decoder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_insn_i   (in_insn_i),
        .wr_valid_o  (wr_valid),
        .wr_ready_i  (wr_ready),
        .wr_data_o   (wr_data),
        .cfg_valid_o (cfg_valid),
        .cfg_o       (cfg),
        .cfg_take_i  (cfg_take)
    );

    insn_ring_buffer #(
        .DEPTH (DEPTH)
    ) u_buffer (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_valid_i (wr_valid),
        .wr_ready_o (wr_ready),
        .wr_data_i  (wr_data),
        .rd_valid_i (rd_valid),
        .rd_ready_o (rd_ready),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data),
        .advance_i  (advance),
        .step_i     (step),
        .rptr_o     (rptr),
        .empty_o    (buf_empty_o)
    );

    frep_sequencer #(
        .DEPTH (DEPTH)
    ) u_sequencer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_valid_i (cfg_valid),
        .cfg_i       (cfg),
        .cfg_take_o  (cfg_take),
        .rptr_i      (rptr),
        .rd_valid_o  (rd_valid),
        .rd_ready_i  (rd_ready),
        .rd_addr_o   (rd_addr),
        .rd_data_i   (rd_data),
        .advance_o   (advance),
        .step_o      (step),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_insn_o  (out_insn_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_frep_top.sv
/*
 * FREP front end testbench
 * Directed tests drive instruction words into the decoder, a queue
 * model expands every block into its repeated body and a monitor
 * compares each issued word against that model
 */

`timescale 1ns/1ps
`default_nettype none

module tb_frep_top;

    import frep_pkg::*;

    localparam int DEPTH   = 16;
    localparam int TIMEOUT = 2000;

    logic  clk_i;
    logic  rst_n_i;
    logic  in_valid_i;
    logic  in_ready_o;
    insn_u in_insn_i;
    logic  out_valid_o;
    logic  out_ready_i;
    insn_u out_insn_o;
    logic  buf_empty_o;

    // Output ready policy, 0 always ready, 1 random, 2 held low
    int     ready_mode;
    integer seed;
    int     checks;
    int     errors;
    int     issued;
    // Later stimulus is skipped once any wait has run out
    logic   timed_out;
    insn_u  expected[$];

    frep_top #(
        .DEPTH (DEPTH)
    ) uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_insn_i   (in_insn_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_insn_o  (out_insn_o),
        .buf_empty_o (buf_empty_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Checks and run control
    //////////////////////////////////////////////////

    task automatic check_insn(input insn_u got, input insn_u exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got.raw, exp.raw);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors, %0d words issued", checks, errors, issued);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout at %0t: %s within %0d cycles", $time, what, TIMEOUT);
    endtask

    // Sample just after the falling edge, where all DUT outputs have settled
    initial begin : issue_monitor
        integer rnd;
        forever begin
            @(negedge clk_i);
            rnd = $random(seed);
            out_ready_i = (ready_mode == 0) || (ready_mode == 1 && rnd[0]);
            #1;
            if (rst_n_i && out_valid_o && out_ready_i) begin
                issued++;
                if (expected.size() == 0) begin
                    errors++;
                    $display("Fail at %0t: unexpected output word %h", $time, out_insn_o.raw);
                end else begin
                    check_insn(out_insn_o, expected.pop_front(), "issued word");
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Random operation that is never read as a loop header
    function automatic insn_u random_op();
        insn_u w;
        w.raw = $random(seed);
        if (w.op.opcode == FREP_OPCODE) w.op.opcode = 8'h53;
        return w;
    endfunction

    // The word is held until the decoder accepts it at a rising edge
    task automatic send_word(input insn_u w);
        int waited;
        waited = 0;
        if (!timed_out) begin
            in_valid_i = 1'b1;
            in_insn_i  = w;
            #1;
            while (!in_ready_o && waited < TIMEOUT) begin
                @(negedge clk_i);
                #1;
                waited++;
            end
            if (!in_ready_o) begin
                in_valid_i = 1'b0;
                report_timeout("input word was not accepted");
            end else begin
                @(negedge clk_i);
                in_valid_i = 1'b0;
            end
        end
    endtask

    task automatic send_single(input insn_u w);
        expected.push_back(w);
        send_word(w);
    endtask

    // Model first, since body words may issue before the block is sent
    task automatic send_block(input int len, input int rep);
        insn_u hdr;
        insn_u body[16];
        hdr.raw             = '0;
        hdr.hdr.opcode      = FREP_OPCODE;
        hdr.hdr.max_rep     = 12'(rep);
        hdr.hdr.body_len_m1 = 4'(len - 1);
        for (int i = 0; i < len; i++) body[i] = random_op();
        for (int r = 0; r <= rep; r++) begin
            for (int i = 0; i < len; i++) expected.push_back(body[i]);
        end
        send_word(hdr);
        for (int i = 0; i < len; i++) send_word(body[i]);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        if (!timed_out) begin
            while (expected.size() != 0 && waited < TIMEOUT) begin
                @(negedge clk_i);
                #2;
                waited++;
            end
            if (expected.size() != 0) begin
                report_timeout("output stream did not drain");
            end else begin
                // The last accepted word leaves at the next rising edge and frees its block
                @(negedge clk_i);
                #2;
                check_bit(buf_empty_o, 1'b1, "buffer empty after drain");
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        check_bit(in_ready_o, 1'b1, "in_ready after reset");
        check_bit(buf_empty_o, 1'b1, "buf_empty after reset");
        check_bit(out_valid_o, 1'b0, "out_valid after reset");
    endtask

    task automatic test_loops_and_singles();
        ready_mode = 0;
        for (int i = 0; i < 6; i++) send_single(random_op());
        wait_drain();
        // Body of three words, replayed three times
        send_block(3, 2);
        wait_drain();
    endtask

    task automatic test_backpressure_wrap();
        int unsigned r;
        int          len;
        ready_mode = 1;
        send_block(2, 1);
        send_single(random_op());
        send_block(5, 3);
        // Enough blocks to wrap the pointers several times
        for (int i = 0; i < 14; i++) begin
            r   = $random(seed);
            len = (i % 4 == 0) ? 16 : int'(r % 16) + 1;
            send_block(len, int'((r >> 8) % 3));
            if (r[4]) send_single(random_op());
        end
        wait_drain();
    endtask

    task automatic test_full_buffer();
        insn_u w;
        ready_mode = 2;
        @(negedge clk_i);
        send_block(DEPTH, 1);
        w = random_op();
        in_valid_i = 1'b1;
        in_insn_i  = w;
        #1;
        check_bit(in_ready_o, 1'b0, "in_ready with full buffer");
        check_bit(buf_empty_o, 1'b0, "buf_empty with full buffer");
        ready_mode = 0;
        send_single(w);
        wait_drain();
    endtask

    initial begin
        seed        = 32'h4e22_f379;
        checks      = 0;
        errors      = 0;
        issued      = 0;
        timed_out   = 1'b0;
        ready_mode  = 0;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_insn_i   = '0;
        out_ready_i = 1'b0;
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;
        #1;
        test_reset_state();
        @(negedge clk_i);
        test_loops_and_singles();
        if (!timed_out) begin
            test_backpressure_wrap();
        end
        if (!timed_out) begin
            test_full_buffer();
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/frep_pkg.sv
verilog/insn_ring_buffer.sv
verilog/frep_decoder.sv
verilog/frep_sequencer.sv
verilog/frep_top.sv
sim/tb_frep_top.sv

//--- run.sh
#!/bin/sh
# Build and run the FREP front end testbench with Verilator

rm -rf obj_dir sim.log &&
verilator --binary -j 0 -f sources.f --top-module tb_frep_top -o sim_frep &&
./obj_dir/sim_frep > sim.log 2>&1 ||
{ echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
